// File: run_sim.sh
#!/bin/sh
# Build and run the issue-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_multi_warp_dispatcher
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o sim_exe
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_exe" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

echo "No failure found in $LOG"
exit 0

// File: src.f
src/bgpu_pkg.sv
src/reg_scoreboard.sv
src/warp_dispatcher.sv
src/warp_rr_arbiter.sv
src/multi_warp_dispatcher.sv
verif/tb_multi_warp_dispatcher.sv

// File: src/bgpu_pkg.sv
/* Fixed sizes for the issue stage. NumWarps and NumTags must stay powers of two
   Instruction id packs the warp id above the per-warp tag */
package bgpu_pkg;

    // ####################
    // Sizes
    // ####################

    // Warps per compute unit
    localparam int unsigned NumWarps        = 4;
    // In-flight instructions per warp
    localparam int unsigned NumTags         = 4;
    // Wait-buffer entries per warp
    localparam int unsigned WaitBufferSize  = 4;
    localparam int unsigned RegIdxWidth     = 6;
    localparam int unsigned OperandsPerInst = 2;
    localparam int unsigned PcWidth         = 32;
    // Threads per warp
    localparam int unsigned WarpWidth       = 32;

    // Derived, not to be edited by hand
    localparam int unsigned WidWidth   = $clog2(NumWarps);
    localparam int unsigned TagWidth   = $clog2(NumTags);
    localparam int unsigned NumRegs    = 2 ** RegIdxWidth;
    localparam int unsigned WbIdxWidth = $clog2(WaitBufferSize);
    // Needs to hold the value WaitBufferSize itself
    localparam int unsigned WbCntWidth = $clog2(WaitBufferSize + 1);

    // ####################
    // Scalar types
    // ####################

    typedef logic [WidWidth-1:0]          wid_t;
    typedef logic [TagWidth-1:0]          tag_t;
    // Warp id in the upper bits, tag in the lower bits
    typedef logic [WidWidth+TagWidth-1:0] iid_t;
    typedef logic [RegIdxWidth-1:0]       reg_idx_t;
    typedef logic [PcWidth-1:0]           pc_t;
    typedef logic [WarpWidth-1:0]         act_mask_t;
    // Wait-buffer position and occupancy
    typedef logic [WbIdxWidth-1:0]        wb_idx_t;
    typedef logic [WbCntWidth-1:0]        wb_cnt_t;

    // ####################
    // Structs
    // ####################

    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] subtype;
    } bgpu_inst_t;

    // Everything the decoder hands over with one instruction
    typedef struct packed {
        pc_t                               pc;
        act_mask_t                         act_mask;
        bgpu_inst_t                        inst;
        reg_idx_t                          dst;
        reg_idx_t [OperandsPerInst-1:0]    operands;
    } dec_inst_t;

    // Dispatched instruction with its id
    typedef struct packed {
        iid_t      iid;
        dec_inst_t dec;
    } disp_req_t;

endpackage : bgpu_pkg

// File: src/multi_warp_dispatcher.sv
/* Issue stage top: one dispatcher per warp and a round-robin pick toward the
   operand collector. Ids on disp_req_o and eu_iid_i are warp id over tag */
`timescale 1ns/1ps

module multi_warp_dispatcher (
    input  logic                          clk_i,
    input  logic                          reset_i,

    // Fetcher
    input  logic                          fe_handshake_i,
    input  bgpu_pkg::wid_t                fe_warp_id_i,
    output logic [bgpu_pkg::NumWarps-1:0] ib_space_available_o,

    // Decoder
    input  logic                          dec_valid_i,
    input  bgpu_pkg::wid_t                dec_warp_id_i,
    input  bgpu_pkg::dec_inst_t           dec_inst_i,
    output logic                          ib_ready_o,

    // Operand collector
    output logic                          disp_valid_o,
    output bgpu_pkg::disp_req_t           disp_req_o,
    input  logic                          opc_ready_i,

    // Execution units
    input  logic                          eu_valid_i,
    input  bgpu_pkg::iid_t                eu_iid_i
);
    import bgpu_pkg::*;

    // ####################
    // Signals
    // ####################

    logic [NumWarps-1:0] fe_handshake_warp, dec_valid_warp, eu_valid_warp;
    logic [NumWarps-1:0] ib_ready_warp;

    // Per-warp offers and grants
    logic [NumWarps-1:0] req_warp, gnt_warp;
    disp_req_t           req_data [NumWarps];
    wid_t                arb_idx;

    // Warp bits of the returning id
    wid_t                eu_wid;
    assign eu_wid = eu_iid_i[WidWidth+TagWidth-1:TagWidth];

    // ####################
    // Warp-id decoders
    // ####################

    always_comb begin
        fe_handshake_warp = '0;
        fe_handshake_warp[fe_warp_id_i] = fe_handshake_i;
    end

    always_comb begin
        dec_valid_warp = '0;
        dec_valid_warp[dec_warp_id_i] = dec_valid_i;
    end

    always_comb begin
        eu_valid_warp = '0;
        eu_valid_warp[eu_wid] = eu_valid_i;
    end

    // Ready of the warp the decoder addresses
    assign ib_ready_o = ib_ready_warp[dec_warp_id_i];

    for (genvar w = 0; w < NumWarps; w++) begin : gen_warp
        warp_dispatcher i_warp_dispatcher (
            .clk_i            ( clk_i                   ),
            .reset_i          ( reset_i                 ),
            .fe_handshake_i   ( fe_handshake_warp[w]    ),
            .space_available_o( ib_space_available_o[w] ),
            .dec_valid_i      ( dec_valid_warp[w]       ),
            .dec_ready_o      ( ib_ready_warp[w]        ),
            .dec_inst_i       ( dec_inst_i              ),
            .disp_valid_o     ( req_warp[w]             ),
            .disp_req_o       ( req_data[w]             ),
            .disp_gnt_i       ( gnt_warp[w]             ),
            .wb_valid_i       ( eu_valid_warp[w]        ),
            .wb_tag_i         ( eu_iid_i[TagWidth-1:0]  )
        );
    end : gen_warp

    // ####################
    // Arbitration
    // ####################

    warp_rr_arbiter i_warp_rr_arbiter (
        .clk_i  ( clk_i        ),
        .reset_i( reset_i      ),
        .req_i  ( req_warp     ),
        .gnt_o  ( gnt_warp     ),
        .idx_o  ( arb_idx      ),
        .valid_o( disp_valid_o ),
        .ready_i( opc_ready_i  )
    );

    // Warp id goes on top of the winner's tag
    assign disp_req_o.iid = {arb_idx, req_data[arb_idx].iid[TagWidth-1:0]};
    assign disp_req_o.dec = req_data[arb_idx].dec;

endmodule : multi_warp_dispatcher

// File: src/reg_scoreboard.sv
/* One instance per warp. pending_o and tag_free_o come from registered state only,
   so a writeback takes effect one cycle after its edge (no bypass) */
`timescale 1ns/1ps

module reg_scoreboard (
    input  logic                              clk_i,
    input  logic                              reset_i,

    // Allocation on dispatch
    input  logic                              alloc_i,
    input  bgpu_pkg::reg_idx_t                alloc_dst_i,
    output bgpu_pkg::tag_t                    alloc_tag_o,
    output logic                              tag_free_o,

    // Release on writeback
    input  logic                              release_i,
    input  bgpu_pkg::tag_t                    release_tag_i,

    // Registers awaiting a result
    output logic [bgpu_pkg::NumRegs-1:0]      pending_o
);
    import bgpu_pkg::*;

    // ####################
    // Per-tag state
    // ####################

    // Busy flag per tag
    logic [NumTags-1:0] busy_q;
    // Destination register of the instruction holding each tag
    reg_idx_t           dst_q [NumTags];

    // ####################
    // Tag search
    // ####################

    // Lowest free tag wins
    always_comb begin
        tag_free_o  = 1'b0;
        alloc_tag_o = '0;
        for (int unsigned t = 0; t < NumTags; t++) begin
            if (!tag_free_o && !busy_q[t]) begin
                tag_free_o  = 1'b1;
                alloc_tag_o = tag_t'(t);
            end
        end
    end

    // Pending set is the OR of all busy destinations
    always_comb begin
        pending_o = '0;
        for (int unsigned t = 0; t < NumTags; t++) begin
            if (busy_q[t]) begin
                pending_o[dst_q[t]] = 1'b1;
            end
        end
    end

    // ####################
    // State update
    // ####################

    // Release and allocate never hit the same tag, a free tag cannot be released
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            if (release_i) begin
                busy_q[release_tag_i] <= 1'b0;
            end
            if (alloc_i) begin
                busy_q[alloc_tag_o] <= 1'b1;
            end
        end
    end

    // Destination only meaningful while busy
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            dst_q[alloc_tag_o] <= alloc_dst_i;
        end
    end

    // Execution units only return ids that were dispatched and not yet returned
    a_release_busy : assert property (
        @(posedge clk_i) disable iff (reset_i)
        release_i |-> busy_q[release_tag_i]
    ) else $error("writeback of a tag that is not in flight");

endmodule : reg_scoreboard

// File: src/warp_dispatcher.sv
/* Wait buffer of one warp, kept compacted with the oldest entry at index 0
   Fetch must only reserve while space_available_o is high; decoder inserts consume
   reservations. disp_req_o carries only the tag, warp bits are zero */
`timescale 1ns/1ps

module warp_dispatcher (
    input  logic                clk_i,
    input  logic                reset_i,

    // Fetcher reservation
    input  logic                fe_handshake_i,
    output logic                space_available_o,

    // Decoder
    input  logic                dec_valid_i,
    output logic                dec_ready_o,
    input  bgpu_pkg::dec_inst_t dec_inst_i,

    // Toward the arbiter
    output logic                disp_valid_o,
    output bgpu_pkg::disp_req_t disp_req_o,
    input  logic                disp_gnt_i,

    // Writeback
    input  logic                wb_valid_i,
    input  bgpu_pkg::tag_t      wb_tag_i
);
    import bgpu_pkg::*;

    // ####################
    // Signals
    // ####################

    // Wait buffer, valid bits form a prefix
    dec_inst_t                  buf_q [WaitBufferSize];
    dec_inst_t                  buf_d [WaitBufferSize];
    logic [WaitBufferSize-1:0]  valid_q, valid_d;

    // Outstanding reservations
    wb_cnt_t                    res_q, res_d;
    wb_cnt_t                    num_entries;

    logic                       insert, disp_fire;
    wb_idx_t                    fill_idx, sel_idx;
    logic [WaitBufferSize-1:0]  entry_ready;
    logic                       any_ready;

    // Scoreboard answers
    logic [NumRegs-1:0]         pending;
    tag_t                       alloc_tag;
    logic                       tag_free;

    // ####################
    // Occupancy
    // ####################

    always_comb begin
        num_entries = '0;
        for (int unsigned i = 0; i < WaitBufferSize; i++) begin
            num_entries = num_entries + wb_cnt_t'(valid_q[i]);
        end
    end

    // Ready while a reservation is left to consume
    assign dec_ready_o       = (res_q != '0);
    assign insert            = dec_valid_i && dec_ready_o;
    // Entries plus reservations must stay within the buffer
    assign space_available_o = (num_entries + res_q) < WaitBufferSize;

    always_comb begin
        res_d = res_q;
        case ({fe_handshake_i, insert})
            2'b10:   res_d = res_q + wb_cnt_t'(1);
            2'b01:   res_d = res_q - wb_cnt_t'(1);
            default: res_d = res_q;
        endcase
    end

    // ####################
    // Hazard check
    // ####################

    // RAW on operands, WAW on destination
    always_comb begin
        for (int unsigned i = 0; i < WaitBufferSize; i++) begin
            entry_ready[i] = valid_q[i] && !pending[buf_q[i].dst];
            for (int unsigned op = 0; op < OperandsPerInst; op++) begin
                entry_ready[i] &= !pending[buf_q[i].operands[op]];
            end
        end
    end

    // Oldest eligible entry
    always_comb begin
        any_ready = 1'b0;
        sel_idx   = '0;
        for (int unsigned i = 0; i < WaitBufferSize; i++) begin
            if (!any_ready && entry_ready[i]) begin
                any_ready = 1'b1;
                sel_idx   = wb_idx_t'(i);
            end
        end
    end

    // No offer without a free tag
    assign disp_valid_o   = any_ready && tag_free;
    assign disp_req_o.iid = iid_t'(alloc_tag);
    assign disp_req_o.dec = buf_q[sel_idx];
    assign disp_fire      = disp_valid_o && disp_gnt_i;

    // ####################
    // Buffer update
    // ####################

    // First free slot once the dispatched entry is gone
    assign fill_idx = wb_idx_t'(num_entries - wb_cnt_t'(disp_fire));

    always_comb begin
        buf_d   = buf_q;
        valid_d = valid_q;
        // Close the gap left by the dispatched entry
        if (disp_fire) begin
            for (int unsigned i = 0; i < WaitBufferSize - 1; i++) begin
                if (i >= sel_idx) begin
                    buf_d[i]   = buf_q[i+1];
                    valid_d[i] = valid_q[i+1];
                end
            end
            valid_d[WaitBufferSize-1] = 1'b0;
        end
        if (insert) begin
            buf_d[fill_idx]   = dec_inst_i;
            valid_d[fill_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
            res_q   <= '0;
        end else begin
            valid_q <= valid_d;
            res_q   <= res_d;
        end
    end

    always_ff @(posedge clk_i) begin
        buf_q <= buf_d;
    end

    reg_scoreboard i_reg_scoreboard (
        .clk_i        ( clk_i           ),
        .reset_i      ( reset_i         ),
        .alloc_i      ( disp_fire       ),
        .alloc_dst_i  ( buf_q[sel_idx].dst ),
        .alloc_tag_o  ( alloc_tag       ),
        .tag_free_o   ( tag_free        ),
        .release_i    ( wb_valid_i      ),
        .release_tag_i( wb_tag_i        ),
        .pending_o    ( pending         )
    );

    // Decoder only presents instructions for warps it fetched for
    a_insert_reserved : assert property (
        @(posedge clk_i) disable iff (reset_i)
        dec_valid_i |-> dec_ready_o
    ) else $error("decoder insert without a reservation");

    // Fetcher respects the space bit
    a_reserve_space : assert property (
        @(posedge clk_i) disable iff (reset_i)
        fe_handshake_i |-> space_available_o
    ) else $error("fetch reservation beyond the free slots");

endmodule : warp_dispatcher

// File: src/warp_rr_arbiter.sv
/* Round-robin over NumWarps requesters with a pointer that wraps by truncation
   Without lock-in the winner may change while ready_i is low */
`timescale 1ns/1ps

module warp_rr_arbiter (
    input  logic                          clk_i,
    input  logic                          reset_i,

    input  logic [bgpu_pkg::NumWarps-1:0] req_i,
    output logic [bgpu_pkg::NumWarps-1:0] gnt_o,

    // Toward the operand collector
    output bgpu_pkg::wid_t                idx_o,
    output logic                          valid_o,
    input  logic                          ready_i
);
    import bgpu_pkg::*;

    // ####################
    // Priority pointer
    // ####################

    // Highest-priority warp this cycle
    wid_t ptr_q;
    wid_t cand;
    logic found;

    // First requester at or after the pointer
    always_comb begin
        found = 1'b0;
        idx_o = ptr_q;
        cand  = ptr_q;
        for (int unsigned off = 0; off < NumWarps; off++) begin
            cand = ptr_q + wid_t'(off);
            if (!found && req_i[cand]) begin
                found = 1'b1;
                idx_o = cand;
            end
        end
    end

    assign valid_o = found;

    // Grant only on an actual transfer
    always_comb begin
        gnt_o = '0;
        gnt_o[idx_o] = valid_o && ready_i;
    end

    // Winner drops to lowest priority after a transfer
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (valid_o && ready_i) begin
            ptr_q <= idx_o + wid_t'(1);
        end
    end

    // Any other requester beats the previous winner right after its transfer
    a_rr_rotate : assert property (
        @(posedge clk_i) disable iff (reset_i)
        (valid_o && ready_i) |=>
            ((req_i & ~(NumWarps'(1) << $past(idx_o))) == '0) ||
            (idx_o != $past(idx_o))
    ) else $error("round-robin winner kept priority after its transfer");

endmodule : warp_rr_arbiter

// File: verif/tb_multi_warp_dispatcher.sv
/* Random fetch, insert and writeback traffic against a shadow model of the issue stage
   Directed burst right after reset expects the round-robin pointer at warp 0 */
`timescale 1ns/1ps

module tb_multi_warp_dispatcher;
    import bgpu_pkg::*;

    // Instructions over the whole run, directed ones included
    localparam int unsigned NumInsts      = 400;
    localparam int unsigned TimeoutCycles = NumInsts * 20;
    // Small register range so hazards are frequent
    localparam int unsigned RegRange      = 8;

    logic                clk_i, reset_i;
    logic                fe_handshake_i;
    wid_t                fe_warp_id_i;
    logic [NumWarps-1:0] ib_space_available_o;
    logic                dec_valid_i;
    wid_t                dec_warp_id_i;
    dec_inst_t           dec_inst_i;
    logic                ib_ready_o;
    logic                disp_valid_o;
    disp_req_t           disp_req_o;
    logic                opc_ready_i;
    logic                eu_valid_i;
    iid_t                eu_iid_i;

    int                  seed;
    int unsigned         error_count, cycle_count, fetch_count;
    int unsigned         insert_count, dispatch_count, wb_count;
    logic                reset_q = 1'b1;
    logic                burst_active;
    wid_t                burst_idx;
    // Dispatched ids waiting for their writeback
    iid_t                return_q [$];

    // ####################
    // Shadow model
    // ####################

    dec_inst_t           model_buf [NumWarps][WaitBufferSize];
    int unsigned         model_cnt [NumWarps];
    int unsigned         model_res [NumWarps];
    logic [NumRegs-1:0]  model_regs [NumWarps];
    logic [NumTags-1:0]  model_tags [NumWarps];
    reg_idx_t            model_tag_dst [NumWarps][NumTags];
    wid_t                model_ptr;

    // Expected offers derived from the model
    logic [NumWarps-1:0] exp_req, exp_space;
    int unsigned         exp_sel [NumWarps];
    dec_inst_t           exp_inst [NumWarps];
    wid_t                exp_winner, disp_wid;
    tag_t                disp_tag;
    logic                exp_ready, disp_hazard, disp_tag_busy;

    multi_warp_dispatcher i_multi_warp_dispatcher (
        .clk_i               ( clk_i                ),
        .reset_i             ( reset_i              ),
        .fe_handshake_i      ( fe_handshake_i       ),
        .fe_warp_id_i        ( fe_warp_id_i         ),
        .ib_space_available_o( ib_space_available_o ),
        .dec_valid_i         ( dec_valid_i          ),
        .dec_warp_id_i       ( dec_warp_id_i        ),
        .dec_inst_i          ( dec_inst_i           ),
        .ib_ready_o          ( ib_ready_o           ),
        .disp_valid_o        ( disp_valid_o         ),
        .disp_req_o          ( disp_req_o           ),
        .opc_ready_i         ( opc_ready_i          ),
        .eu_valid_i          ( eu_valid_i           ),
        .eu_iid_i            ( eu_iid_i             )
    );

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // RAW on operands or WAW on destination
    function automatic logic touches_inflight(input dec_inst_t inst,
                                              input logic [NumRegs-1:0] regs);
        logic hit;
        hit = regs[inst.dst];
        for (int unsigned op = 0; op < OperandsPerInst; op++) begin
            hit = hit | regs[inst.operands[op]];
        end
        return hit;
    endfunction

    function automatic dec_inst_t random_inst();
        dec_inst_t inst;
        inst.pc           = pc_t'($random(seed));
        inst.act_mask     = act_mask_t'($random(seed));
        inst.inst.opcode  = 8'($random(seed));
        inst.inst.subtype = 8'($random(seed));
        inst.dst          = reg_idx_t'(rand_below(RegRange));
        for (int unsigned op = 0; op < OperandsPerInst; op++) begin
            inst.operands[op] = reg_idx_t'(rand_below(RegRange));
        end
        return inst;
    endfunction

    // Distinct destinations above the random range, shared read-only sources
    function automatic dec_inst_t indep_inst(input int unsigned w, input int unsigned k);
        dec_inst_t inst;
        inst.pc           = pc_t'(w * 256 + k * 4);
        inst.act_mask     = '1;
        inst.inst.opcode  = 8'(w + 1);
        inst.inst.subtype = 8'(k);
        inst.dst          = reg_idx_t'(16 + 2 * w + k);
        inst.operands[0]  = reg_idx_t'(40);
        inst.operands[1]  = reg_idx_t'(41);
        return inst;
    endfunction

    task automatic report_mismatch(input string what);
        error_count++;
        $display("[ERROR] %0t: %s", $time, what);
    endtask

    // Reserve a slot, then insert into it on the next cycle
    task automatic buffer_inst(input wid_t w, input dec_inst_t inst);
        fe_handshake_i = 1'b1;
        fe_warp_id_i   = w;
        fetch_count++;
        @(posedge clk_i);
        #1;
        fe_handshake_i = 1'b0;
        dec_valid_i    = 1'b1;
        dec_warp_id_i  = w;
        dec_inst_i     = inst;
        @(posedge clk_i);
        #1;
        dec_valid_i    = 1'b0;
    endtask

    always_comb begin : expected_offers
        logic found;
        wid_t cand;
        for (int unsigned w = 0; w < NumWarps; w++) begin
            exp_req[w]  = 1'b0;
            exp_sel[w]  = 0;
            exp_inst[w] = '0;
            // Oldest entry clear of in-flight registers
            for (int unsigned i = 0; i < WaitBufferSize; i++) begin
                if (!exp_req[w] && i < model_cnt[w] &&
                    !touches_inflight(model_buf[w][i], model_regs[w])) begin
                    exp_req[w]  = 1'b1;
                    exp_sel[w]  = i;
                    exp_inst[w] = model_buf[w][i];
                end
            end
            // All tags busy, nothing offered
            if (&model_tags[w]) begin
                exp_req[w] = 1'b0;
            end
            exp_space[w] = (model_cnt[w] + model_res[w]) < WaitBufferSize;
        end
        found      = 1'b0;
        exp_winner = model_ptr;
        for (int unsigned off = 0; off < NumWarps; off++) begin
            cand = model_ptr + wid_t'(off);
            if (!found && exp_req[cand]) begin
                found      = 1'b1;
                exp_winner = cand;
            end
        end
    end

    assign disp_wid      = disp_req_o.iid[WidWidth+TagWidth-1:TagWidth];
    assign disp_tag      = disp_req_o.iid[TagWidth-1:0];
    assign disp_hazard   = touches_inflight(disp_req_o.dec, model_regs[disp_wid]);
    assign disp_tag_busy = model_tags[disp_wid][disp_tag];
    assign exp_ready     = model_res[dec_warp_id_i] != 0;

    always @(posedge clk_i) begin : model_update
        dec_inst_t   line [WaitBufferSize];
        int unsigned cnt;
        logic        fire, ins, fe_hit, ins_hit, fire_hit;
        fire = disp_valid_o && opc_ready_i;
        ins  = dec_valid_i && exp_ready;
        if (reset_i) begin
            for (int unsigned w = 0; w < NumWarps; w++) begin
                model_cnt[w]  <= 0;
                model_res[w]  <= 0;
                model_regs[w] <= '0;
                model_tags[w] <= '0;
            end
            model_ptr      <= '0;
            insert_count   <= 0;
            dispatch_count <= 0;
            wb_count       <= 0;
            return_q.delete();
        end else begin
            for (int unsigned w = 0; w < NumWarps; w++) begin
                fe_hit   = fe_handshake_i && fe_warp_id_i == wid_t'(w);
                ins_hit  = ins && dec_warp_id_i == wid_t'(w);
                fire_hit = fire && disp_wid == wid_t'(w);
                // Queue without the dispatched entry, new one appended
                cnt = 0;
                for (int unsigned i = 0; i < WaitBufferSize; i++) begin
                    line[i] = model_buf[w][i];
                end
                for (int unsigned i = 0; i < WaitBufferSize; i++) begin
                    if (i < model_cnt[w] && !(fire_hit && i == exp_sel[w])) begin
                        line[cnt] = model_buf[w][i];
                        cnt++;
                    end
                end
                if (ins_hit && cnt < WaitBufferSize) begin
                    line[cnt] = dec_inst_i;
                    cnt++;
                end
                for (int unsigned i = 0; i < WaitBufferSize; i++) begin
                    model_buf[w][i] <= line[i];
                end
                model_cnt[w] <= cnt;
                model_res[w] <= model_res[w] + 32'(fe_hit) - 32'(ins_hit);
            end
            if (fire) begin
                model_tags[disp_wid][disp_tag]           <= 1'b1;
                model_regs[disp_wid][disp_req_o.dec.dst] <= 1'b1;
                model_tag_dst[disp_wid][disp_tag]        <= disp_req_o.dec.dst;
                model_ptr      <= exp_winner + wid_t'(1);
                dispatch_count <= dispatch_count + 1;
                return_q.push_back(disp_req_o.iid);
            end
            if (eu_valid_i) begin
                model_tags[eu_iid_i[3:2]][eu_iid_i[1:0]] <= 1'b0;
                model_regs[eu_iid_i[3:2]][model_tag_dst[eu_iid_i[3:2]][eu_iid_i[1:0]]] <= 1'b0;
                wb_count <= wb_count + 1;
            end
            if (ins) begin
                insert_count <= insert_count + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        reset_q <= reset_i;
        if (reset_i) begin
            burst_idx <= '0;
        end else if (burst_active) begin
            burst_idx <= burst_idx + wid_t'(1);
        end
    end

    // ####################
    // Checks
    // ####################

    a_reset_state : assert property (@(posedge clk_i) disable iff (reset_i)
        reset_q |-> !disp_valid_o && !ib_ready_o && (&ib_space_available_o)
    ) else report_mismatch("outputs not idle in the first cycle after reset");

    a_disp_valid : assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o == (|exp_req)
    ) else report_mismatch("disp_valid_o differs from the model");

    a_disp_warp : assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o |-> disp_wid == exp_winner
    ) else report_mismatch("dispatched warp is not the round-robin winner");

    a_disp_payload : assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o |-> disp_req_o.dec == exp_inst[disp_wid]
    ) else report_mismatch("payload is not the oldest eligible instruction");

    a_disp_hazard : assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o |-> !disp_hazard
    ) else report_mismatch("dispatched instruction touches an in-flight register");

    a_disp_tag : assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o |-> !disp_tag_busy
    ) else report_mismatch("dispatched id is still in flight");

    a_ib_ready : assert property (@(posedge clk_i) disable iff (reset_i)
        ib_ready_o == exp_ready
    ) else report_mismatch("ib_ready_o differs from the reservation count");

    a_space : assert property (@(posedge clk_i) disable iff (reset_i)
        ib_space_available_o == exp_space
    ) else report_mismatch("space bits differ from entries plus reservations");

    a_burst_order : assert property (@(posedge clk_i) disable iff (reset_i)
        burst_active |-> disp_valid_o && disp_wid == burst_idx
    ) else report_mismatch("burst grant order is not 0, 1, 2, 3");

    // ####################
    // Clock, timeout, writebacks
    // ####################

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions written back",
                     cycle_count, wb_count, NumInsts);
            $display("test failed");
            $finish;
        end
    end

    // Random pick from the return queue, so writebacks come out of order
    initial begin : writeback_driver
        int unsigned pick;
        eu_valid_i = 1'b0;
        eu_iid_i   = '0;
        forever begin
            @(posedge clk_i);
            #1;
            eu_valid_i = 1'b0;
            if (return_q.size() > 0 && rand_below(4) != 0) begin
                pick       = rand_below($unsigned(return_q.size()));
                eu_iid_i   = return_q[pick];
                eu_valid_i = 1'b1;
                return_q.delete(pick);
            end
        end
    end

    initial begin : main_sequence
        int unsigned start;
        wid_t        w;
        seed           = 72;
        error_count    = 0;
        cycle_count    = 0;
        fetch_count    = 0;
        reset_i        = 1'b1;
        fe_handshake_i = 1'b0;
        fe_warp_id_i   = '0;
        dec_valid_i    = 1'b0;
        dec_warp_id_i  = '0;
        dec_inst_i     = '0;
        opc_ready_i    = 1'b0;
        burst_active   = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Two independent instructions per warp, then back-pressure
        for (int unsigned k = 0; k < 2; k++) begin
            for (int unsigned v = 0; v < NumWarps; v++) begin
                buffer_inst(wid_t'(v), indep_inst(v, k));
            end
        end
        repeat (10) begin
            @(posedge clk_i);
            #1;
        end
        burst_active = 1'b1;
        opc_ready_i  = 1'b1;
        repeat (NumWarps) @(posedge clk_i);
        #1;
        burst_active = 1'b0;

        // Random traffic until every instruction is inserted
        while (fetch_count < NumInsts || insert_count < NumInsts) begin
            fe_handshake_i = 1'b0;
            dec_valid_i    = 1'b0;
            start          = rand_below(NumWarps);
            if (fetch_count < NumInsts && rand_below(4) != 0) begin
                for (int unsigned k = 0; k < NumWarps; k++) begin
                    w = wid_t'(start + k);
                    if (!fe_handshake_i && ib_space_available_o[w]) begin
                        fe_handshake_i = 1'b1;
                        fe_warp_id_i   = w;
                        fetch_count++;
                    end
                end
            end
            start = rand_below(NumWarps);
            if (rand_below(4) != 0) begin
                for (int unsigned k = 0; k < NumWarps; k++) begin
                    w = wid_t'(start + k);
                    if (!dec_valid_i && model_res[w] != 0) begin
                        dec_valid_i   = 1'b1;
                        dec_warp_id_i = w;
                        dec_inst_i    = random_inst();
                    end
                end
            end
            opc_ready_i = rand_below(3) != 0;
            @(posedge clk_i);
            #1;
        end
        fe_handshake_i = 1'b0;
        dec_valid_i    = 1'b0;
        opc_ready_i    = 1'b1;
        wait (wb_count == NumInsts);
        @(posedge clk_i);
        #1;

        // Every inserted instruction left exactly once
        assert (dispatch_count == NumInsts && insert_count == NumInsts)
            else report_mismatch("dispatch count differs from insert count");
        for (int unsigned v = 0; v < NumWarps; v++) begin
            assert (model_cnt[v] == 0 && model_res[v] == 0)
                else report_mismatch("wait buffer not empty at the end");
        end
        $display("Run finished: %0d errors, %0d inserted, %0d dispatched, %0d written back",
                 error_count, insert_count, dispatch_count, wb_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_multi_warp_dispatcher
